//--- cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and address widths
`define CPU_XLEN            32
`define CPU_ADDR_W          16

// on-chip memory depths in words
`define CPU_IM_WORDS        64
`define CPU_DM_WORDS        32

// boot image sizes in words
`define CPU_BOOT_IM_WORDS   16
`define CPU_BOOT_DM_WORDS   8

// host address map
`define CPU_HOST_IM_BASE    16'h0000
`define CPU_HOST_DM_BASE    16'h1000
`define CPU_HOST_OUT_BASE   16'h9000  // stores at or above go to the host

`endif

//--- cpu_pkg.sv
package cpu_pkg;

`include "cpu_config.svh"

    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_ADD  = 8'h10,
        OP_SUB  = 8'h11,
        OP_AND  = 8'h12,
        OP_OR   = 8'h13,
        OP_XOR  = 8'h14,
        OP_ADDI = 8'h18,
        OP_LW   = 8'h20,
        OP_SW   = 8'h28,
        OP_BEQ  = 8'h31,
        OP_BNE  = 8'h33,
        OP_JMP  = 8'h3D
    } opcode_e;

    // register form rd = rs op rt
    typedef struct packed {
        opcode_e     opcode;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [3:0]  rt;
        logic [11:0] unused;
    } instr_r_t;

    // immediate form for addi, lw, sw, branches and jmp
    typedef struct packed {
        opcode_e     opcode;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [15:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    // decoded control that travels down the stage registers
    typedef struct packed {
        opcode_e    alu_op;
        logic       use_imm;
        logic       rf_wen;
        logic       mem_wen;
        logic       mem_ren;
        logic       wb_from_mem;
        logic       is_branch;
        logic [3:0] wb_reg;
    } ctrl_t;

    localparam ctrl_t CTRL_NOP = '0;

    typedef struct packed {
        logic                   req;
        logic                   write;
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_XLEN-1:0]   wdata;
    } host_req_t;

    typedef struct packed {
        logic                 ack;
        logic [`CPU_XLEN-1:0] rdata;
    } host_rsp_t;

endpackage

//--- cpu_mem.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_mem #(
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [`CPU_XLEN-1:0]     wr_data,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [`CPU_XLEN-1:0]     rd_data
);

    logic [`CPU_XLEN-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    assign rd_data = mem[rd_addr];  // async read

endmodule

//--- cpu_regfile.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [3:0]           rs_sel,
    input  logic [3:0]           rt_sel,
    output logic [`CPU_XLEN-1:0] rs_data,
    output logic [`CPU_XLEN-1:0] rt_data,
    input  logic                 wr_en,
    input  logic [3:0]           wr_sel,
    input  logic [`CPU_XLEN-1:0] wr_data
);

    logic [`CPU_XLEN-1:0] regs [16];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != 4'd0) begin  // r0 never written
            regs[wr_sel] <= wr_data;
        end
    end

    assign rs_data = regs[rs_sel];
    assign rt_data = regs[rt_sel];

    r0_is_zero: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
        else $error("r0 holds a nonzero value");

endmodule

//--- cpu_alu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_alu (
    input  cpu_pkg::opcode_e     op,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    output logic [`CPU_XLEN-1:0] result,
    output logic                 taken
);
    import cpu_pkg::*;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (op)
            OP_ADD, OP_ADDI: result = a + b;
            OP_LW, OP_SW:    result = a + b;  // effective address
            OP_SUB:          result = a - b;
            OP_AND:          result = a & b;
            OP_OR:           result = a | b;
            OP_XOR:          result = a ^ b;
            // branches compare rs against rd directly
            OP_BEQ:          taken = (a == b);
            OP_BNE:          taken = (a != b);
            OP_JMP:          taken = 1'b1;
            default:         ;
        endcase
    end

endmodule

//--- cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode (
    input  cpu_pkg::instr_u instr,
    input  cpu_pkg::ctrl_t  ex_ctrl,
    input  cpu_pkg::ctrl_t  mem_ctrl,
    input  cpu_pkg::ctrl_t  wb_ctrl,
    output cpu_pkg::ctrl_t  ctrl,
    output logic            stall
);
    import cpu_pkg::*;

    logic use_rs;
    logic use_rt;
    logic use_rd;
    logic raw;

    // true if src is still to be written by EX, MEM or WB
    function automatic logic busy(input logic [3:0] src);
        return src != 4'd0 &&
               ((ex_ctrl.rf_wen  && ex_ctrl.wb_reg  == src) ||
                (mem_ctrl.rf_wen && mem_ctrl.wb_reg == src) ||
                (wb_ctrl.rf_wen  && wb_ctrl.wb_reg  == src));
    endfunction

    // a bubble or nop further down must not look like a writer
    function automatic logic nop_clean(input ctrl_t c);
        return c.alu_op != OP_NOP || !(c.rf_wen || c.mem_wen);
    endfunction

    always_comb begin
        ctrl        = CTRL_NOP;
        ctrl.alu_op = instr.r.opcode;
        ctrl.wb_reg = instr.r.rd;
        use_rs      = 1'b1;
        use_rt      = 1'b0;
        use_rd      = 1'b0;
        case (instr.r.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                ctrl.rf_wen = 1'b1;
                use_rt      = 1'b1;
            end
            OP_ADDI: begin
                ctrl.use_imm = 1'b1;
                ctrl.rf_wen  = 1'b1;
            end
            OP_LW: begin
                ctrl.use_imm     = 1'b1;
                ctrl.rf_wen      = 1'b1;
                ctrl.mem_ren     = 1'b1;
                ctrl.wb_from_mem = 1'b1;
            end
            OP_SW: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_wen = 1'b1;
                use_rd       = 1'b1;  // store data
            end
            OP_BEQ, OP_BNE: begin
                ctrl.is_branch = 1'b1;
                use_rd         = 1'b1;
            end
            OP_JMP: begin
                ctrl.is_branch = 1'b1;
                use_rs         = 1'b0;
            end
            default: begin  // nop and unknown opcodes
                ctrl   = CTRL_NOP;
                use_rs = 1'b0;
            end
        endcase
    end

    always_comb begin
        raw = (use_rs && busy(instr.r.rs)) ||
              (use_rt && busy(instr.r.rt)) ||
              (use_rd && busy(instr.r.rd));
        stage_nop_clean: assert #0 (nop_clean(ex_ctrl) && nop_clean(mem_ctrl)
                                    && nop_clean(wb_ctrl))
            else $error("nop control in a later stage carries a write enable");
    end

    assign stall = raw || ex_ctrl.is_branch;  // branch in EX blocks ID too

endmodule

//--- cpu_host_link.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_host_link (
    input  logic                             clk,
    input  logic                             rst_n,
    output cpu_pkg::host_req_t               host_req,
    input  cpu_pkg::host_rsp_t               host_rsp,
    input  logic                             out_store_valid,
    input  logic [`CPU_ADDR_W-1:0]           out_store_addr,
    input  logic [`CPU_XLEN-1:0]             out_store_data,
    output logic                             boot_wr_en,
    output logic                             boot_im_sel,
    output logic [$clog2(`CPU_IM_WORDS)-1:0] boot_wr_addr,
    output logic [`CPU_XLEN-1:0]             boot_wr_data,
    output logic                             run,
    output logic                             freeze
);

    localparam int BOOT_TOTAL = `CPU_BOOT_IM_WORDS + `CPU_BOOT_DM_WORDS;
    localparam int CNT_W      = $clog2(BOOT_TOTAL);
    localparam int IM_AW      = $clog2(`CPU_IM_WORDS);

    typedef enum logic [2:0] {
        ST_BOOT_REQ,
        ST_BOOT_REL,
        ST_RUN,
        ST_OUT_REQ,
        ST_OUT_REL
    } state_e;

    state_e                 state;
    state_e                 state_nx;
    logic [CNT_W-1:0]       boot_cnt;
    logic [CNT_W-1:0]       boot_idx;
    logic [`CPU_ADDR_W-1:0] boot_addr;
    logic                   sent;  // store in MEM already written out

    //////////////////////////////////////////////////////////////////////
    // boot addressing with the program image first and the data image after

    assign boot_im_sel  = boot_cnt < CNT_W'(`CPU_BOOT_IM_WORDS);
    assign boot_idx     = boot_im_sel ? boot_cnt : boot_cnt - CNT_W'(`CPU_BOOT_IM_WORDS);
    assign boot_addr    = (boot_im_sel ? `CPU_HOST_IM_BASE : `CPU_HOST_DM_BASE)
                        + `CPU_ADDR_W'({boot_idx, 2'b00});
    assign boot_wr_en   = state == ST_BOOT_REQ && host_rsp.ack;
    assign boot_wr_addr = IM_AW'(boot_idx);
    assign boot_wr_data = host_rsp.rdata;

    assign run    = state inside {ST_RUN, ST_OUT_REQ, ST_OUT_REL};
    assign freeze = (state == ST_RUN && out_store_valid && !sent)
                  || state inside {ST_OUT_REQ, ST_OUT_REL};

    always_comb begin
        host_req = '0;
        case (state)
            ST_BOOT_REQ: begin
                host_req.req  = 1'b1;
                host_req.addr = boot_addr;
            end
            ST_OUT_REQ: begin
                host_req.req   = 1'b1;
                host_req.write = 1'b1;
                host_req.addr  = out_store_addr;  // held while the core is frozen
                host_req.wdata = out_store_data;
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // four-phase sequencing

    always_comb begin
        state_nx = state;
        case (state)
            ST_BOOT_REQ: if (host_rsp.ack) state_nx = ST_BOOT_REL;
            ST_BOOT_REL: begin
                if (!host_rsp.ack) begin
                    state_nx = (boot_cnt == CNT_W'(BOOT_TOTAL - 1)) ? ST_RUN : ST_BOOT_REQ;
                end
            end
            ST_RUN:      if (out_store_valid && !sent) state_nx = ST_OUT_REQ;
            ST_OUT_REQ:  if (host_rsp.ack) state_nx = ST_OUT_REL;
            ST_OUT_REL:  if (!host_rsp.ack) state_nx = ST_RUN;
            default:     state_nx = ST_BOOT_REL;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_BOOT_REL;  // idle release so the count wraps to word 0
            boot_cnt <= '1;
            sent     <= 1'b0;
        end else begin
            state <= state_nx;
            sent  <= state == ST_OUT_REL && !host_rsp.ack;  // one cycle to let the store go
            if (state == ST_BOOT_REL && state_nx == ST_BOOT_REQ) begin
                boot_cnt <= boot_cnt + 1'b1;
            end
        end
    end

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        host_req.req && !host_rsp.ack |=> host_req.req)
        else $error("req dropped before ack");

    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        host_req.req && !host_rsp.ack |=> $stable(host_req.addr) && $stable(host_req.wdata))
        else $error("host request changed while waiting for ack");

endmodule

//--- cpu_core.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_core (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             run,
    input  logic                             freeze,
    output logic [$clog2(`CPU_IM_WORDS)-1:0] im_addr,
    input  logic [`CPU_XLEN-1:0]             im_data,
    output logic                             dm_wr_en,
    output logic [$clog2(`CPU_DM_WORDS)-1:0] dm_addr,
    output logic [`CPU_XLEN-1:0]             dm_wr_data,
    input  logic [`CPU_XLEN-1:0]             dm_rd_data,
    output logic                             out_store_valid,
    output logic [`CPU_ADDR_W-1:0]           out_store_addr,
    output logic [`CPU_XLEN-1:0]             out_store_data
);
    import cpu_pkg::*;

    localparam int IM_AW = $clog2(`CPU_IM_WORDS);
    localparam int DM_AW = $clog2(`CPU_DM_WORDS);

    typedef struct packed {
        ctrl_t                ctrl;
        logic [`CPU_XLEN-1:0] a;    // rs
        logic [`CPU_XLEN-1:0] b;    // rt, or rd for stores and branches
        logic [`CPU_XLEN-1:0] imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [`CPU_XLEN-1:0] alu;
        logic [`CPU_XLEN-1:0] store;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [`CPU_XLEN-1:0] alu;
        logic [`CPU_XLEN-1:0] mem;
    } mem_wb_t;

    logic [`CPU_ADDR_W-1:0] pc;
    instr_u                 if_id;
    id_ex_t                 id_ex;
    ex_mem_t                ex_mem;
    mem_wb_t                mem_wb;

    ctrl_t                id_ctrl;
    logic                 stall;
    logic [3:0]           rt_sel;
    logic [`CPU_XLEN-1:0] rs_data;
    logic [`CPU_XLEN-1:0] rt_data;
    logic [`CPU_XLEN-1:0] alu_b;
    logic [`CPU_XLEN-1:0] alu_res;
    logic [`CPU_XLEN-1:0] wb_data;
    logic                 taken;
    logic                 advance;
    logic                 redirect;
    logic                 is_out;

    assign advance  = run && !freeze;
    assign redirect = id_ex.ctrl.is_branch && taken;

    //////////////////////////////////////////////////////////////////////
    // fetch

    assign im_addr = pc[IM_AW+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (advance) begin
            if (redirect) begin
                pc <= id_ex.imm[`CPU_ADDR_W-1:0];
            end else if (!stall && !id_ctrl.is_branch) begin
                pc <= pc + `CPU_ADDR_W'(4);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id <= '0;
        end else if (advance && !stall) begin
            if_id <= id_ctrl.is_branch ? '0 : im_data;  // no fetch behind a branch
        end
    end

    //////////////////////////////////////////////////////////////////////
    // decode and register read

    cpu_decode u_decode (
        .instr    (if_id),
        .ex_ctrl  (id_ex.ctrl),
        .mem_ctrl (ex_mem.ctrl),
        .wb_ctrl  (mem_wb.ctrl),
        .ctrl     (id_ctrl),
        .stall    (stall)
    );

    assign rt_sel = (id_ctrl.mem_wen || id_ctrl.is_branch) ? if_id.r.rd : if_id.r.rt;

    cpu_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_sel  (if_id.r.rs),
        .rt_sel  (rt_sel),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (mem_wb.ctrl.rf_wen),
        .wr_sel  (mem_wb.ctrl.wb_reg),
        .wr_data (wb_data)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (advance) begin
            if (stall) begin
                id_ex <= '0;  // bubble
            end else begin
                id_ex <= '{ctrl: id_ctrl, a: rs_data, b: rt_data,
                           imm: `CPU_XLEN'(if_id.i.imm)};
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // execute, memory, write-back

    assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.b;

    cpu_alu u_alu (
        .op     (id_ex.ctrl.alu_op),
        .a      (id_ex.a),
        .b      (alu_b),
        .result (alu_res),
        .taken  (taken)
    );

    // high stores leave through the host link
    assign is_out = ex_mem.ctrl.mem_wen && ex_mem.alu[`CPU_ADDR_W-1:0] >= `CPU_HOST_OUT_BASE;

    assign dm_wr_en        = ex_mem.ctrl.mem_wen && !is_out;
    assign dm_addr         = ex_mem.alu[DM_AW+1:2];
    assign dm_wr_data      = ex_mem.store;
    assign out_store_valid = is_out;
    assign out_store_addr  = ex_mem.alu[`CPU_ADDR_W-1:0];
    assign out_store_data  = ex_mem.store;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
            mem_wb <= '0;
        end else if (advance) begin
            ex_mem <= '{ctrl: id_ex.ctrl, alu: alu_res, store: id_ex.b};
            mem_wb <= '{ctrl: ex_mem.ctrl, alu: ex_mem.alu,
                        mem: ex_mem.ctrl.mem_ren ? dm_rd_data : '0};  // loads only
        end
    end

    assign wb_data = mem_wb.ctrl.wb_from_mem ? mem_wb.mem : mem_wb.alu;

endmodule

//--- cpu_top.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top (
    input  logic               clk,
    input  logic               rst_n,
    output cpu_pkg::host_req_t host_req,
    input  cpu_pkg::host_rsp_t host_rsp
);

    localparam int IM_AW = $clog2(`CPU_IM_WORDS);
    localparam int DM_AW = $clog2(`CPU_DM_WORDS);

    logic                   run;
    logic                   freeze;
    logic [IM_AW-1:0]       im_addr;
    logic [`CPU_XLEN-1:0]   im_data;
    logic                   core_dm_wr_en;
    logic [DM_AW-1:0]       core_dm_addr;
    logic [`CPU_XLEN-1:0]   core_dm_wr_data;
    logic [`CPU_XLEN-1:0]   dm_rd_data;
    logic                   out_store_valid;
    logic [`CPU_ADDR_W-1:0] out_store_addr;
    logic [`CPU_XLEN-1:0]   out_store_data;
    logic                   boot_wr_en;
    logic                   boot_im_sel;
    logic [IM_AW-1:0]       boot_wr_addr;
    logic [`CPU_XLEN-1:0]   boot_wr_data;
    logic                   dm_we;
    logic [DM_AW-1:0]       dm_wa;
    logic [`CPU_XLEN-1:0]   dm_wd;

    // boot loader owns the data memory write port until run
    assign dm_we = boot_wr_en ? !boot_im_sel : core_dm_wr_en;
    assign dm_wa = boot_wr_en ? boot_wr_addr[DM_AW-1:0] : core_dm_addr;
    assign dm_wd = boot_wr_en ? boot_wr_data : core_dm_wr_data;

    cpu_core u_core (
        .clk             (clk),
        .rst_n           (rst_n),
        .run             (run),
        .freeze          (freeze),
        .im_addr         (im_addr),
        .im_data         (im_data),
        .dm_wr_en        (core_dm_wr_en),
        .dm_addr         (core_dm_addr),
        .dm_wr_data      (core_dm_wr_data),
        .dm_rd_data      (dm_rd_data),
        .out_store_valid (out_store_valid),
        .out_store_addr  (out_store_addr),
        .out_store_data  (out_store_data)
    );

    cpu_host_link u_host_link (
        .clk             (clk),
        .rst_n           (rst_n),
        .host_req        (host_req),
        .host_rsp        (host_rsp),
        .out_store_valid (out_store_valid),
        .out_store_addr  (out_store_addr),
        .out_store_data  (out_store_data),
        .boot_wr_en      (boot_wr_en),
        .boot_im_sel     (boot_im_sel),
        .boot_wr_addr    (boot_wr_addr),
        .boot_wr_data    (boot_wr_data),
        .run             (run),
        .freeze          (freeze)
    );

    cpu_mem #(.DEPTH(`CPU_IM_WORDS)) u_imem (
        .clk     (clk),
        .wr_en   (boot_wr_en && boot_im_sel),
        .wr_addr (boot_wr_addr),
        .wr_data (boot_wr_data),
        .rd_addr (im_addr),
        .rd_data (im_data)
    );

    cpu_mem #(.DEPTH(`CPU_DM_WORDS)) u_dmem (
        .clk     (clk),
        .wr_en   (dm_we),
        .wr_addr (dm_wa),
        .wr_data (dm_wd),
        .rd_addr (core_dm_addr),
        .rd_data (dm_rd_data)
    );

endmodule

//--- tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam logic [15:0] POISON_ADDR = 16'h9F00;
    localparam int          BOOT_READS  = `CPU_BOOT_IM_WORDS + `CPU_BOOT_DM_WORDS;
    localparam int          N_OUT       = 2;

    logic      clk;
    logic      rst_n;
    host_req_t host_req;
    host_rsp_t host_rsp = '0;

    logic [31:0] lfsr = 32'hc77f4db1;
    logic [31:0] program_img [`CPU_BOOT_IM_WORDS];
    logic [31:0] data_img [`CPU_BOOT_DM_WORDS];
    logic [31:0] exp_out [N_OUT];
    int          n_reads = 0;
    int          n_writes = 0;
    int          delay = 0;
    logic        pending = 1'b0;
    int          err_boot = 0;
    int          err_arith = 0;
    int          err_flow = 0;
    int          err_bp = 0;
    int          n_fail;

    cpu_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .host_req (host_req),
        .host_rsp (host_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_i(opcode_e op, int rd, int rs, logic [15:0] imm);
        return {op, 4'(rd), 4'(rs), imm};
    endfunction

    function automatic logic [31:0] enc_r(opcode_e op, int rd, int rs, int rt);
        return {op, 4'(rd), 4'(rs), 4'(rt), 12'h000};
    endfunction

    function automatic logic [31:0] host_read_word(logic [15:0] addr);
        if (addr < `CPU_HOST_DM_BASE) begin
            return program_img[(addr - `CPU_HOST_IM_BASE) >> 2];
        end
        return data_img[(addr - `CPU_HOST_DM_BASE) >> 2];
    endfunction

    // program words first, then data words, four bytes apart
    function automatic logic [15:0] expected_boot_addr(int n);
        if (n < `CPU_BOOT_IM_WORDS) begin
            return 16'(`CPU_HOST_IM_BASE + 4 * n);
        end
        return 16'(`CPU_HOST_DM_BASE + 4 * (n - `CPU_BOOT_IM_WORDS));
    endfunction

    //////////////////////////////////////////////////////////////////////
    // host model with a random ack delay per transfer

    always @(posedge clk) begin
        if (!rst_n) begin
            host_rsp <= '0;
            pending  <= 1'b0;
        end else if (host_rsp.ack) begin
            if (!host_req.req) host_rsp.ack <= 1'b0;  // phase 4
        end else if (host_req.req) begin
            if (!pending) begin
                pending <= 1'b1;
                delay   <= int'(lfsr_bits(3));
            end else if (delay != 0) begin
                delay <= delay - 1;
            end else begin
                pending      <= 1'b0;
                host_rsp.ack <= 1'b1;
                if (!host_req.write) begin
                    assert (n_reads < BOOT_READS
                            && host_req.addr == expected_boot_addr(n_reads))
                    else begin
                        err_boot++;
                        $display("[FAIL] boot_order read %0d expected addr %h actual %h",
                                 n_reads, expected_boot_addr(n_reads), host_req.addr);
                    end
                    host_rsp.rdata <= host_read_word(host_req.addr);
                    n_reads        <= n_reads + 1;
                end else begin
                    assert (n_reads == BOOT_READS) else begin
                        err_boot++;
                        $display("write request seen before the boot finished");
                    end
                    assert (host_req.addr != POISON_ADDR) else begin
                        err_flow++;
                        $display("a skipped store reached the poison address");
                    end
                    if (host_req.addr != POISON_ADDR) begin
                        assert (n_writes < N_OUT) else begin
                            err_bp++;
                            $display("extra host write to %h", host_req.addr);
                        end
                        if (n_writes < N_OUT) begin
                            assert (host_req.addr == 16'(`CPU_HOST_OUT_BASE + 4 * n_writes))
                            else begin
                                err_flow++;
                                $display("[FAIL] control_flow write %0d expected addr %h actual %h",
                                         n_writes, 16'(`CPU_HOST_OUT_BASE + 4 * n_writes),
                                         host_req.addr);
                            end
                            assert (host_req.wdata == exp_out[n_writes]) else begin
                                err_arith++;
                                $display("[FAIL] arith_mem_hazard result %0d expected %h actual %h",
                                         n_writes, exp_out[n_writes], host_req.wdata);
                            end
                        end
                        n_writes <= n_writes + 1;
                    end
                end
            end
        end
    end

    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        host_req.req && !host_rsp.ack |=> host_req.req && $stable(host_req.addr)
                                          && $stable(host_req.wdata))
        else begin
            err_bp++;
            $display("host request changed or dropped before ack");
        end

    //////////////////////////////////////////////////////////////////////
    // program, data image and expected results

    task automatic build_images();
        logic [31:0] r3;
        logic [31:0] r4;
        logic [31:0] r7;
        for (int k = 0; k < `CPU_BOOT_DM_WORDS; k++) begin
            data_img[k] = lfsr_bits(32);
        end
        program_img[0]  = enc_i(OP_LW,   1, 0, 16'h0000);
        program_img[1]  = enc_i(OP_LW,   2, 0, 16'h0004);
        program_img[2]  = enc_r(OP_ADD,  3, 1, 2);
        program_img[3]  = enc_r(OP_SUB,  4, 3, 2);   // back-to-back dependents
        program_img[4]  = enc_r(OP_AND,  5, 3, 1);
        program_img[5]  = enc_r(OP_OR,   6, 5, 2);
        program_img[6]  = enc_r(OP_XOR,  7, 6, 4);
        program_img[7]  = enc_i(OP_ADDI, 8, 7, 16'h1234);
        program_img[8]  = enc_i(OP_SW,   8, 0, 16'h0008);  // data memory word 2
        program_img[9]  = enc_i(OP_LW,   9, 0, 16'h0008);
        program_img[10] = enc_i(OP_SW,   3, 0, `CPU_HOST_OUT_BASE);
        program_img[11] = enc_i(OP_BEQ,  4, 1, 16'd52);    // taken
        program_img[12] = enc_i(OP_SW,   2, 0, POISON_ADDR);
        program_img[13] = enc_i(OP_BNE,  9, 8, 16'd60);    // not taken
        program_img[14] = enc_i(OP_SW,   9, 0, `CPU_HOST_OUT_BASE + 16'h0004);
        program_img[15] = enc_i(OP_JMP,  0, 0, 16'd60);    // park here
        r3 = data_img[0] + data_img[1];
        r4 = r3 - data_img[1];
        r7 = (((r3 & data_img[0]) | data_img[1]) ^ r4);
        exp_out[0] = r3;
        exp_out[1] = r7 + 32'h0000_1234;
    endtask

    task automatic report(string name, int errs);
        if (errs == 0) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errs);
    endtask

    initial begin
        int   t;
        logic stopped;
        rst_n   = 1'b0;
        stopped = 1'b0;
        build_images();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        t = 0;
        while (n_reads < BOOT_READS && t < 1000) begin
            @(posedge clk);
            t++;
        end
        if (n_reads < BOOT_READS) begin
            $display("boot did not finish in time, %0d reads", n_reads);
            err_boot++;
            stopped = 1'b1;
        end
        report("boot_order", err_boot);

        if (!stopped) begin
            t = 0;
            while (n_writes < N_OUT && t < 3000) begin
                @(posedge clk);
                t++;
            end
            if (n_writes < N_OUT) begin
                $display("program stopped short, %0d host writes", n_writes);
                err_bp++;
                stopped = 1'b1;
            end
        end

        if (!stopped) begin
            t = 0;
            while (t < 200) begin  // idle window to catch late or duplicate writes
                @(posedge clk);
                t++;
            end
        end
        report("arith_mem_hazard", err_arith);
        report("control_flow", err_flow);
        report("back_pressure", err_bp);

        n_fail = (err_boot != 0) + (err_arith != 0) + (err_flow != 0) + (err_bp != 0);
        $display("tests run 4, passed %0d, failed %0d", 4 - n_fail, n_fail);
        if (n_fail == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+.
cpu_pkg.sv
cpu_mem.sv
cpu_regfile.sv
cpu_alu.sv
cpu_decode.sv
cpu_host_link.sv
cpu_core.sv
cpu_top.sv
tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_cpu
FILELIST  := files.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
